//--- logic/shell_pkg.sv
package shell_pkg;

    // ------------------------------
    // Widths with a meaning
    // ------------------------------
    typedef logic [27:0] byte_addr_t;
    typedef logic [63:0] word_t;
    typedef logic [7:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [14:0] vox_addr_t;
    typedef logic [9:0]  mem_index_t;
    typedef logic [17:0] pixel_index_t;
    typedef logic [23:0] rgb_t;
    typedef logic [31:0] count_t;
    typedef logic [15:0] coord_t;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // ------------------------------
    // Address map
    // ------------------------------
    // Voxel window at the bottom, 256 KiB
    localparam byte_addr_t VOX_WIN_BYTES = 28'h004_0000;
    // BAR1 aliases the low space from 16 MiB up
    localparam byte_addr_t BAR1_BASE     = 28'h100_0000;
    // SDRAM words sit directly above the voxel window
    localparam byte_addr_t MEM_BASE      = VOX_WIN_BYTES;
    localparam int         MEM_WORDS     = 1024;

    // Screen geometry of the pixel stream
    localparam int SCREEN_WIDTH  = 480;
    localparam int SCREEN_HEIGHT = 360;
    localparam int TOTAL_PIXELS  = SCREEN_WIDTH * SCREEN_HEIGHT;

    // Execute stage states, shared by both targets
    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } port_state_t;

endpackage

//--- logic/mem_window_decode.sv
`timescale 1ns/1ps

module mem_window_decode (
    input  shell_pkg::byte_addr_t wr_addr,
    input  shell_pkg::byte_addr_t rd_addr,
    input  logic                  wr_valid,
    input  logic                  rd_valid,
    output logic                  vox_wr_valid,
    output logic                  vox_rd_valid,
    output logic                  mem_wr_valid,
    output logic                  mem_rd_valid,
    output logic                  wr_is_vox,
    output logic                  rd_is_vox,
    output shell_pkg::mem_index_t wr_index,
    output shell_pkg::mem_index_t rd_index,
    output logic                  wr_range_err,
    output logic                  rd_range_err,
    output shell_pkg::vox_addr_t  vox_addr
);
    import shell_pkg::*;

    byte_addr_t wr_off;
    byte_addr_t rd_off;

    // Byte offset into SDRAM with BAR1 folded down first
    // A BAR1 offset below the SDRAM base wraps to a huge value and fails the range check
    function automatic byte_addr_t mem_offset(input byte_addr_t addr);
        byte_addr_t local_addr;
        local_addr = (addr >= BAR1_BASE) ? addr - BAR1_BASE : addr;
        return local_addr - MEM_BASE;
    endfunction

    // ------------------------------
    // Classification
    // ------------------------------
    assign wr_is_vox = (wr_addr < VOX_WIN_BYTES);
    assign rd_is_vox = (rd_addr < VOX_WIN_BYTES);

    assign wr_off = mem_offset(wr_addr);
    assign rd_off = mem_offset(rd_addr);

    assign wr_index     = mem_index_t'(wr_off >> 3);
    assign rd_index     = mem_index_t'(rd_off >> 3);
    assign wr_range_err = (wr_off >> 3) >= byte_addr_t'(MEM_WORDS);
    assign rd_range_err = (rd_off >> 3) >= byte_addr_t'(MEM_WORDS);

    // Voxel word address from byte address bits 17..3
    assign vox_addr = wr_addr[17:3];

    // Each valid goes to exactly one target
    assign vox_wr_valid = wr_valid && wr_is_vox;
    assign mem_wr_valid = wr_valid && !wr_is_vox;
    assign vox_rd_valid = rd_valid && rd_is_vox;
    assign mem_rd_valid = rd_valid && !rd_is_vox;

endmodule

//--- logic/voxel_window_port.sv
`timescale 1ns/1ps

module voxel_window_port (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_valid,
    input  logic                 rd_valid,
    input  shell_pkg::vox_addr_t vox_addr_in,
    input  shell_pkg::word_t     wdata,
    input  logic                 bready,
    input  logic                 rready,
    output logic                 wr_ready,
    output logic                 rd_ready,
    output logic                 bvalid,
    output logic                 rvalid,
    output logic                 vox_we,
    output shell_pkg::vox_addr_t vox_addr,
    output shell_pkg::word_t     vox_data
);
    import shell_pkg::*;

    port_state_t state;
    logic        wr_accept;
    logic        rd_accept;

    // Write wins when both arrive in the same cycle
    assign wr_ready  = (state == IDLE);
    assign rd_ready  = (state == IDLE) && !wr_valid;
    assign wr_accept = wr_valid && wr_ready;
    assign rd_accept = rd_valid && rd_ready;

    // ------------------------------
    // Response FSM and store strobe
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            vox_we <= 1'b0;
        end else begin
            vox_we <= wr_accept;
            case (state)
                IDLE: begin
                    if (wr_accept) begin
                        state <= WRITE_RESP;
                    end else if (rd_accept) begin
                        state <= READ_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (bready) begin
                        state <= IDLE;
                    end
                end
                READ_RESP: begin
                    if (rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Store address and data, captured with the strobe
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            vox_addr <= vox_addr_in;
            vox_data <= wdata;
        end
    end

    // Always OKAY here; reads carry zero data from the top
    assign bvalid = (state == WRITE_RESP);
    assign rvalid = (state == READ_RESP);

    assert property (@(posedge clk) disable iff (!rst_n) vox_we |=> !vox_we)
        else $error("vox_we held for more than one cycle");

endmodule

//--- logic/sdram_model.sv
`timescale 1ns/1ps

module sdram_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_valid,
    input  logic                  rd_valid,
    input  shell_pkg::mem_index_t wr_index,
    input  shell_pkg::mem_index_t rd_index,
    input  logic                  wr_err,
    input  logic                  rd_err,
    input  shell_pkg::word_t      wdata,
    input  shell_pkg::strb_t      wstrb,
    input  logic                  bready,
    input  logic                  rready,
    output logic                  wr_ready,
    output logic                  rd_ready,
    output logic                  bvalid,
    output shell_pkg::resp_t      bresp,
    output logic                  rvalid,
    output shell_pkg::word_t      rdata,
    output shell_pkg::resp_t      rresp
);
    import shell_pkg::*;

    word_t       mem [MEM_WORDS];
    port_state_t state;
    logic        wr_accept;
    logic        rd_accept;

    // One request at a time, write first
    assign wr_ready  = (state == IDLE);
    assign rd_ready  = (state == IDLE) && !wr_valid;
    assign wr_accept = wr_valid && wr_ready;
    assign rd_accept = rd_valid && rd_ready;

    // ------------------------------
    // Response FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_accept) begin
                        state <= WRITE_RESP;
                    end else if (rd_accept) begin
                        state <= READ_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (bready) begin
                        state <= IDLE;
                    end
                end
                READ_RESP: begin
                    if (rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign bvalid = (state == WRITE_RESP);
    assign rvalid = (state == READ_RESP);

    // ------------------------------
    // Storage and response payload
    // ------------------------------
    always_ff @(posedge clk) begin
        // Out-of-range writes leave the array alone
        if (wr_accept && !wr_err) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wstrb[b]) begin
                    mem[wr_index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        if (wr_accept) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_accept) begin
            rdata <= rd_err ? '0 : mem[rd_index];
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

//--- logic/pixel_stream_monitor.sv
`timescale 1ns/1ps

module pixel_stream_monitor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pixel_write_en,
    input  shell_pkg::pixel_index_t pixel_addr,
    input  logic [31:0]             pixel_word,
    output shell_pkg::rgb_t         tdata,
    output logic                    tvalid,
    output logic                    tuser,
    output logic                    tlast,
    output shell_pkg::count_t       beat_count,
    output shell_pkg::count_t       frame_count,
    output shell_pkg::coord_t       line_count,
    output shell_pkg::coord_t       pixel_in_line
);
    import shell_pkg::*;

    logic line_end;

    // ------------------------------
    // Stream formation
    // ------------------------------
    // Upper byte of the pixel word is not part of the colour
    assign tdata  = pixel_word[23:0];
    assign tvalid = pixel_write_en;
    // Frame markers only on real beats
    assign tuser  = pixel_write_en && (pixel_addr == pixel_index_t'(0));
    assign tlast  = pixel_write_en && (pixel_addr == pixel_index_t'(TOTAL_PIXELS - 1));

    // Last column of the current line
    assign line_end = (pixel_in_line == coord_t'(SCREEN_WIDTH - 1));

    // ------------------------------
    // Beat, frame and line counters
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_count    <= '0;
            frame_count   <= '0;
            line_count    <= '0;
            pixel_in_line <= '0;
        end else if (tvalid) begin
            beat_count <= beat_count + 1'b1;
            if (tlast) begin
                frame_count <= frame_count + 1'b1;
            end
            if (tuser) begin
                // First pixel of a frame already counts as column one
                pixel_in_line <= coord_t'(1);
                line_count    <= '0;
            end else if (line_end) begin
                pixel_in_line <= '0;
                line_count    <= line_count + 1'b1;
            end else begin
                pixel_in_line <= pixel_in_line + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(tuser && tlast))
        else $error("tuser and tlast high on the same beat");

endmodule

//--- logic/voxel_shell_top.sv
`timescale 1ns/1ps

module voxel_shell_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // External write port
    input  shell_pkg::byte_addr_t   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  shell_pkg::word_t        wdata,
    input  shell_pkg::strb_t        wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output shell_pkg::resp_t        bresp,
    output logic                    bvalid,
    input  logic                    bready,

    // External read port
    input  shell_pkg::byte_addr_t   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output shell_pkg::word_t        rdata,
    output shell_pkg::resp_t        rresp,
    output logic                    rvalid,
    input  logic                    rready,

    // Voxel store strobe
    output logic                    vox_we,
    output shell_pkg::vox_addr_t    vox_addr,
    output shell_pkg::word_t        vox_data,

    // Renderer pixel writes and the stream
    input  logic                    pixel_write_en,
    input  shell_pkg::pixel_index_t pixel_addr,
    input  logic [31:0]             pixel_word,
    output shell_pkg::rgb_t         tdata,
    output logic                    tvalid,
    output logic                    tuser,
    output logic                    tlast,
    output shell_pkg::count_t       beat_count,
    output shell_pkg::count_t       frame_count,
    output shell_pkg::coord_t       line_count,
    output shell_pkg::coord_t       pixel_in_line
);
    import shell_pkg::*;

    logic       wr_valid;
    logic       vox_wr_valid;
    logic       vox_rd_valid;
    logic       mem_wr_valid;
    logic       mem_rd_valid;
    logic       wr_is_vox;
    logic       rd_is_vox;
    mem_index_t wr_index;
    mem_index_t rd_index;
    logic       wr_range_err;
    logic       rd_range_err;
    vox_addr_t  dec_vox_addr;

    logic       vox_wr_ready;
    logic       vox_rd_ready;
    logic       vox_bvalid;
    logic       vox_rvalid;
    logic       mem_wr_ready;
    logic       mem_rd_ready;
    logic       mem_bvalid;
    logic       mem_rvalid;
    resp_t      mem_bresp;
    resp_t      mem_rresp;
    word_t      mem_rdata;

    // Address and data travel together
    assign wr_valid = awvalid && wvalid;

    mem_window_decode u_decode (
        .wr_addr      (awaddr),
        .rd_addr      (araddr),
        .wr_valid     (wr_valid),
        .rd_valid     (arvalid),
        .vox_wr_valid (vox_wr_valid),
        .vox_rd_valid (vox_rd_valid),
        .mem_wr_valid (mem_wr_valid),
        .mem_rd_valid (mem_rd_valid),
        .wr_is_vox    (wr_is_vox),
        .rd_is_vox    (rd_is_vox),
        .wr_index     (wr_index),
        .rd_index     (rd_index),
        .wr_range_err (wr_range_err),
        .rd_range_err (rd_range_err),
        .vox_addr     (dec_vox_addr)
    );

    voxel_window_port u_vox (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_valid    (vox_wr_valid),
        .rd_valid    (vox_rd_valid),
        .vox_addr_in (dec_vox_addr),
        .wdata       (wdata),
        .bready      (bready),
        .rready      (rready),
        .wr_ready    (vox_wr_ready),
        .rd_ready    (vox_rd_ready),
        .bvalid      (vox_bvalid),
        .rvalid      (vox_rvalid),
        .vox_we      (vox_we),
        .vox_addr    (vox_addr),
        .vox_data    (vox_data)
    );

    sdram_model u_sdram (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (mem_wr_valid),
        .rd_valid (mem_rd_valid),
        .wr_index (wr_index),
        .rd_index (rd_index),
        .wr_err   (wr_range_err),
        .rd_err   (rd_range_err),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bready   (bready),
        .rready   (rready),
        .wr_ready (mem_wr_ready),
        .rd_ready (mem_rd_ready),
        .bvalid   (mem_bvalid),
        .bresp    (mem_bresp),
        .rvalid   (mem_rvalid),
        .rdata    (mem_rdata),
        .rresp    (mem_rresp)
    );

    pixel_stream_monitor u_stream (
        .clk            (clk),
        .rst_n          (rst_n),
        .pixel_write_en (pixel_write_en),
        .pixel_addr     (pixel_addr),
        .pixel_word     (pixel_word),
        .tdata          (tdata),
        .tvalid         (tvalid),
        .tuser          (tuser),
        .tlast          (tlast),
        .beat_count     (beat_count),
        .frame_count    (frame_count),
        .line_count     (line_count),
        .pixel_in_line  (pixel_in_line)
    );

    // ------------------------------
    // Ready select and response merge
    // ------------------------------
    assign awready = wr_is_vox ? vox_wr_ready : mem_wr_ready;
    assign wready  = awready;
    assign arready = rd_is_vox ? vox_rd_ready : mem_rd_ready;

    // One write and one read outstanding, so at most one target answers
    assign bvalid = vox_bvalid || mem_bvalid;
    assign bresp  = mem_bvalid ? mem_bresp : RESP_OKAY;
    assign rvalid = vox_rvalid || mem_rvalid;
    assign rdata  = mem_rvalid ? mem_rdata : '0;
    assign rresp  = mem_rvalid ? mem_rresp : RESP_OKAY;

endmodule

//--- sim/tb_voxel_shell.sv
`timescale 1ns/1ps

module tb_voxel_shell;
    import shell_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 40;

    logic         clk;
    logic         rst_n;
    byte_addr_t   awaddr;
    logic         awvalid;
    logic         awready;
    word_t        wdata;
    strb_t        wstrb;
    logic         wvalid;
    logic         wready;
    resp_t        bresp;
    logic         bvalid;
    logic         bready;
    byte_addr_t   araddr;
    logic         arvalid;
    logic         arready;
    word_t        rdata;
    resp_t        rresp;
    logic         rvalid;
    logic         rready;
    logic         vox_we;
    vox_addr_t    vox_addr;
    word_t        vox_data;
    logic         pixel_write_en;
    pixel_index_t pixel_addr;
    logic [31:0]  pixel_word;
    rgb_t         tdata;
    logic         tvalid;
    logic         tuser;
    logic         tlast;
    count_t       beat_count;
    count_t       frame_count;
    coord_t       line_count;
    coord_t       pixel_in_line;

    int     errors;
    int     timeouts;
    integer seed;
    word_t  scoreboard [MEM_WORDS];
    resp_t  exp_bresp;
    resp_t  exp_rresp;
    word_t  exp_rdata;
    logic   vox_accept;

    // Reference model of the stream counters
    count_t m_beats;
    count_t m_frames;
    coord_t m_line;
    coord_t m_pixel;

    voxel_shell_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic mismatch(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic wait_expired(input string what);
        timeouts++;
        $display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what,
                 WAIT_LIMIT);
    endtask

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strb_t strb);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Direct byte address of an SDRAM word
    function automatic byte_addr_t word_addr(input int idx);
        return MEM_BASE + byte_addr_t'(idx * 8);
    endfunction

    task automatic write_word(input byte_addr_t addr, input word_t data, input strb_t strb,
                              input resp_t resp);
        int cycles;
        @(negedge clk);
        awaddr    = addr;
        wdata     = data;
        wstrb     = strb;
        awvalid   = 1'b1;
        wvalid    = 1'b1;
        exp_bresp = resp;
        cycles    = 0;
        #1;
        while (!(awready && wready) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (cycles >= WAIT_LIMIT) begin
            wait_expired("write acceptance");
        end else begin
            cycles = 0;
            while (!bvalid && cycles < WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (cycles >= WAIT_LIMIT) begin
                wait_expired("write response");
            end
            bready = 1'b1;
            @(negedge clk);
            bready = 1'b0;
        end
    endtask

    task automatic read_word(input byte_addr_t addr, input word_t data, input resp_t resp);
        int cycles;
        @(negedge clk);
        araddr    = addr;
        arvalid   = 1'b1;
        exp_rdata = data;
        exp_rresp = resp;
        cycles    = 0;
        #1;
        while (!arready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        if (cycles >= WAIT_LIMIT) begin
            wait_expired("read acceptance");
        end else begin
            cycles = 0;
            while (!rvalid && cycles < WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (cycles >= WAIT_LIMIT) begin
                wait_expired("read response");
            end
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
        end
    endtask

    // Scoreboarded SDRAM store, addr may be direct or through BAR1
    task automatic mem_store(input int idx, input byte_addr_t addr, input word_t data,
                             input strb_t strb);
        scoreboard[idx] = merge_bytes(scoreboard[idx], data, strb);
        write_word(addr, data, strb, RESP_OKAY);
    endtask

    task automatic send_pixel(input pixel_index_t idx);
        @(negedge clk);
        pixel_write_en = 1'b1;
        pixel_addr     = idx;
        pixel_word     = $random(seed);
    endtask

    // ------------------------------
    // Checking
    // ------------------------------
    assign vox_accept = awvalid && wvalid && awready && wready && (awaddr < VOX_WIN_BYTES);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_beats  <= '0;
            m_frames <= '0;
            m_line   <= '0;
            m_pixel  <= '0;
        end else if (pixel_write_en) begin
            m_beats <= m_beats + 32'd1;
            if (pixel_addr == pixel_index_t'(TOTAL_PIXELS - 1)) begin
                m_frames <= m_frames + 32'd1;
            end
            if (pixel_addr == '0) begin
                m_pixel <= 16'd1;
                m_line  <= '0;
            end else if (int'(m_pixel) + 1 == SCREEN_WIDTH) begin
                m_pixel <= '0;
                m_line  <= m_line + 16'd1;
            end else begin
                m_pixel <= m_pixel + 16'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) vox_accept |=>
        (vox_we && vox_addr == $past(awaddr[17:3]) && vox_data == $past(wdata)))
        else mismatch("voxel strobe, address or data wrong after window write");
    assert property (@(posedge clk) disable iff (!rst_n) !vox_accept |=> !vox_we)
        else mismatch("vox_we high without a window write");
    assert property (@(posedge clk) disable iff (!rst_n)
        (awvalid && wvalid && awready && wready) |=> bvalid)
        else mismatch("bvalid not seen one cycle after write acceptance");
    assert property (@(posedge clk) disable iff (!rst_n) (arvalid && arready) |=> rvalid)
        else mismatch("rvalid not seen one cycle after read acceptance");
    assert property (@(posedge clk) disable iff (!rst_n) (bvalid && bready) |->
        bresp == exp_bresp)
        else mismatch("write response code differs from expected");
    assert property (@(posedge clk) disable iff (!rst_n) (rvalid && rready) |->
        (rdata == exp_rdata && rresp == exp_rresp))
        else mismatch("read data or response code differs from expected");

    assert property (@(posedge clk) disable iff (!rst_n) tvalid == pixel_write_en)
        else mismatch("tvalid does not follow pixel_write_en");
    assert property (@(posedge clk) disable iff (!rst_n) tvalid |-> tdata == pixel_word[23:0])
        else mismatch("tdata differs from low 24 bits of pixel_word");
    assert property (@(posedge clk) disable iff (!rst_n)
        tuser == (pixel_write_en && pixel_addr == '0))
        else mismatch("tuser wrong for this pixel index");
    assert property (@(posedge clk) disable iff (!rst_n)
        tlast == (pixel_write_en && pixel_addr == pixel_index_t'(TOTAL_PIXELS - 1)))
        else mismatch("tlast wrong for this pixel index");
    assert property (@(posedge clk) disable iff (!rst_n)
        (beat_count == m_beats && frame_count == m_frames &&
         line_count == m_line && pixel_in_line == m_pixel))
        else mismatch("stream counters differ from the counter model");

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        word_t keep;
        errors         = 0;
        timeouts       = 0;
        seed           = 32'h6618_a121;
        rst_n          = 1'b0;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        pixel_write_en = 1'b0;
        pixel_addr     = '0;
        pixel_word     = '0;
        exp_bresp      = RESP_OKAY;
        exp_rresp      = RESP_OKAY;
        exp_rdata      = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            scoreboard[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Voxel window writes and reads
        write_word(28'h001_2348, {$random(seed), $random(seed)}, 8'hFF, RESP_OKAY);
        for (int i = 0; i < 3; i++) begin
            write_word(byte_addr_t'($random(seed)) & (VOX_WIN_BYTES - 28'd1),
                       {$random(seed), $random(seed)}, 8'hFF, RESP_OKAY);
        end
        read_word(28'h000_0100, '0, RESP_OKAY);
        read_word(VOX_WIN_BYTES - 28'd8, '0, RESP_OKAY);

        // SDRAM full then partial strobe
        mem_store(5, word_addr(5), {$random(seed), $random(seed)}, 8'hFF);
        mem_store(5, word_addr(5), {$random(seed), $random(seed)}, 8'h3C);
        read_word(word_addr(5), scoreboard[5], RESP_OKAY);

        // BAR1 alias in both directions
        mem_store(17, BAR1_BASE + word_addr(17), {$random(seed), $random(seed)}, 8'hFF);
        read_word(word_addr(17), scoreboard[17], RESP_OKAY);
        mem_store(42, word_addr(42), {$random(seed), $random(seed)}, 8'hFF);
        read_word(BAR1_BASE + word_addr(42), scoreboard[42], RESP_OKAY);

        // Beyond the memory, direct and through BAR1
        mem_store(3, word_addr(3), {$random(seed), $random(seed)}, 8'hFF);
        keep = scoreboard[3];
        write_word(word_addr(MEM_WORDS + 3), ~keep, 8'hFF, RESP_SLVERR);
        read_word(word_addr(MEM_WORDS + 3), '0, RESP_SLVERR);
        write_word(BAR1_BASE + word_addr(MEM_WORDS + 3), ~keep, 8'hFF, RESP_SLVERR);
        read_word(BAR1_BASE + word_addr(MEM_WORDS + 3), '0, RESP_SLVERR);
        read_word(word_addr(3), keep, RESP_OKAY);

        // Pixel stream across a line end and a frame end
        for (int i = 0; i < SCREEN_WIDTH + 12; i++) begin
            send_pixel(pixel_index_t'(i));
        end
        send_pixel(pixel_index_t'(TOTAL_PIXELS - 1));
        send_pixel('0);
        send_pixel(pixel_index_t'(1));
        @(negedge clk);
        pixel_write_en = 1'b0;
        repeat (3) @(negedge clk);

        $display("Checks finished: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
logic/shell_pkg.sv
logic/mem_window_decode.sv
logic/voxel_window_port.sv
logic/sdram_model.sv
logic/pixel_stream_monitor.sv
logic/voxel_shell_top.sv
sim/tb_voxel_shell.sv

//--- Makefile
# Verilator build and run of the voxel shell testbench

VERILATOR ?= verilator
TOP       ?= tb_voxel_shell
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "test: pass line found in $(LOG)"; \
	else \
		echo "test: pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
